/* verilog/rvIsaPkg.sv */
//******************
// RV32I instruction encodings used by decode, execute and memory alignment
// referenced by scoped name from the modules that decode or steer on them
//******************
package rvIsaPkg;

	// datapath and register index widths
	localparam int xlen = 32;
	localparam int regAddrW = 5;

	// major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		op     = 7'b0110011,
		opImm  = 7'b0010011,
		load   = 7'b0000011,
		store  = 7'b0100011,
		branch = 7'b1100011,
		jal    = 7'b1101111,
		jalr   = 7'b1100111,
		lui    = 7'b0110111,
		auipc  = 7'b0010111
	} opcodeT;

	// funct3 as seen by the alu ops
	typedef enum logic [2:0] {
		f3Add  = 3'b000,
		f3Sll  = 3'b001,
		f3Slt  = 3'b010,
		f3Sltu = 3'b011,
		f3Xor  = 3'b100,
		f3Sr   = 3'b101,
		f3Or   = 3'b110,
		f3And  = 3'b111
	} funct3T;

	// same field read as a branch condition
	localparam funct3T brEq  = funct3T'(3'b000);
	localparam funct3T brNe  = funct3T'(3'b001);
	localparam funct3T brLt  = funct3T'(3'b100);
	localparam funct3T brGe  = funct3T'(3'b101);
	localparam funct3T brLtu = funct3T'(3'b110);
	localparam funct3T brGeu = funct3T'(3'b111);

	// and as a load/store size, bit 2 marks zero extension
	localparam funct3T memB  = funct3T'(3'b000);
	localparam funct3T memH  = funct3T'(3'b001);
	localparam funct3T memW  = funct3T'(3'b010);
	localparam funct3T memBu = funct3T'(3'b100);
	localparam funct3T memHu = funct3T'(3'b101);

endpackage

/* verilog/coreCtrlPkg.sv */
//******************
// pipeline control encodings shared between decode, hazard and datapath
// also holds the fetch address used out of reset
//******************
package coreCtrlPkg;

	// first fetch address after reset
	localparam logic [31:0] resetVector = 32'h0;

	// alu operation carried down the pipe
	typedef enum logic [3:0] {
		add,
		sub,
		sll,
		slt,
		sltu,
		xorOp,
		srl,
		sra,
		orOp,
		andOp
	} aluOpT;

	// which value execute hands on as its result
	typedef enum logic [1:0] {
		alu,
		pcPlus4,
		immU,
		pcImmU
	} resultSrcT;

	// bypass source for an execute operand
	typedef enum logic [1:0] {
		fwdNone,
		fwdMem,
		fwdWb
	} fwdSelT;

	// next fetch address choice, made in decode
	typedef enum logic [1:0] {
		seq,
		branchTarget,
		jalTarget,
		jalrTarget
	} pcSelT;

endpackage

/* verilog/pcGen.sv */
//******************
// fetch pc register and next-pc select
// targets come from decode, stall freezes the pc
//******************
`timescale 1ns/100ps

module pcGen (
	input logic clk,
	input logic reset,
	input logic stall,
	input coreCtrlPkg::pcSelT pcSel,
	input logic [31:0] branchTarget, jalTarget, jalrTarget,
	output logic [31:0] pc
);

	logic [31:0] pcNext;

	// default is straight-line fetch
	// jalr target already has bit 0 cleared
	always_comb begin
		case (pcSel)
			coreCtrlPkg::branchTarget: pcNext = branchTarget;
			coreCtrlPkg::jalTarget: pcNext = jalTarget;
			coreCtrlPkg::jalrTarget: pcNext = jalrTarget;
			default: pcNext = pc + 32'd4;
		endcase
	end

	// pc holds on a stall, a pending redirect waits with it
	always_ff @(posedge clk) begin
		if (!reset) begin
			pc <= coreCtrlPkg::resetVector;
		end else if (!stall) begin
			pc <= pcNext;
		end
	end

endmodule

/* verilog/instDecode.sv */
//******************
// decode of one RV32I word into fields, control bits and its immediate
// purely combinational, sits after the IF/ID register
//******************
`timescale 1ns/100ps

module instDecode (
	input logic [31:0] instr,
	output logic [4:0] rs1, rs2, rd,
	output coreCtrlPkg::aluOpT aluOp,
	output logic aluSrcImm, regWrite, memRead, memWrite,
	output logic isBranch, isJal, isJalr,
	output coreCtrlPkg::resultSrcT resultSrc,
	output rvIsaPkg::funct3T funct3,
	output logic [31:0] imm
);

	rvIsaPkg::opcodeT opcode;
	coreCtrlPkg::aluOpT aluFunct;
	logic [31:0] iImm, sImm, bImm, uImm, jImm;

	assign opcode = rvIsaPkg::opcodeT'(instr[6:0]);
	assign funct3 = rvIsaPkg::funct3T'(instr[14:12]);
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];

	// immediate formats, all sign extended from bit 31
	assign iImm = {{20{instr[31]}}, instr[31:20]};
	assign sImm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign bImm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign uImm = {instr[31:12], 12'b0};
	assign jImm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// alu op from funct3
	// bit 30 picks sub only for register ops, sra for both shift forms
	always_comb begin
		case (funct3)
			rvIsaPkg::f3Add: begin
				if (opcode == rvIsaPkg::op && instr[30])
					aluFunct = coreCtrlPkg::sub;
				else
					aluFunct = coreCtrlPkg::add;
			end
			rvIsaPkg::f3Sll: aluFunct = coreCtrlPkg::sll;
			rvIsaPkg::f3Slt: aluFunct = coreCtrlPkg::slt;
			rvIsaPkg::f3Sltu: aluFunct = coreCtrlPkg::sltu;
			rvIsaPkg::f3Xor: aluFunct = coreCtrlPkg::xorOp;
			rvIsaPkg::f3Sr: aluFunct = instr[30] ? coreCtrlPkg::sra : coreCtrlPkg::srl;
			rvIsaPkg::f3Or: aluFunct = coreCtrlPkg::orOp;
			default: aluFunct = coreCtrlPkg::andOp;
		endcase
	end

	// control per opcode
	// the defaults form a bubble, which is also what an unknown opcode gets
	always_comb begin
		aluOp = coreCtrlPkg::add;
		aluSrcImm = 1'b0;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		isBranch = 1'b0;
		isJal = 1'b0;
		isJalr = 1'b0;
		resultSrc = coreCtrlPkg::alu;
		imm = iImm;
		case (opcode)
			rvIsaPkg::op: begin
				regWrite = 1'b1;
				aluOp = aluFunct;
			end
			rvIsaPkg::opImm: begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				aluOp = aluFunct;
			end
			// address is rs1 + imm through the adder
			rvIsaPkg::load: begin
				regWrite = 1'b1;
				memRead = 1'b1;
				aluSrcImm = 1'b1;
			end
			rvIsaPkg::store: begin
				memWrite = 1'b1;
				aluSrcImm = 1'b1;
				imm = sImm;
			end
			rvIsaPkg::branch: begin
				isBranch = 1'b1;
				imm = bImm;
			end
			// both jumps link pc+4
			rvIsaPkg::jal: begin
				isJal = 1'b1;
				regWrite = 1'b1;
				resultSrc = coreCtrlPkg::pcPlus4;
				imm = jImm;
			end
			rvIsaPkg::jalr: begin
				isJalr = 1'b1;
				regWrite = 1'b1;
				resultSrc = coreCtrlPkg::pcPlus4;
			end
			rvIsaPkg::lui: begin
				regWrite = 1'b1;
				resultSrc = coreCtrlPkg::immU;
				imm = uImm;
			end
			rvIsaPkg::auipc: begin
				regWrite = 1'b1;
				resultSrc = coreCtrlPkg::pcImmU;
				imm = uImm;
			end
			default: begin
				regWrite = 1'b0;
			end
		endcase
	end

endmodule

/* verilog/regFile.sv */
//******************
// 32 x 32 integer registers, x0 reads as zero
// two combinational reads for decode, one falling-edge write from writeback
//******************
`timescale 1ns/100ps

module regFile (
	input logic clk,
	input logic reset,
	input logic we,
	input logic [rvIsaPkg::regAddrW-1:0] ra1, ra2, wa,
	input logic [rvIsaPkg::xlen-1:0] wd,
	output logic [rvIsaPkg::xlen-1:0] rd1, rd2
);

	logic [rvIsaPkg::xlen-1:0] regs [32];

	// write on the falling edge so decode sees it later in the same cycle
	always_ff @(negedge clk) begin
		if (!reset) begin
			regs <= '{default: '0};
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// x0 forced to zero on read
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

/* verilog/aluExec.sv */
//******************
// execute stage operand bypass, alu and result select
// bypass values come from the memory and writeback stages
//******************
`timescale 1ns/100ps

module aluExec (
	input coreCtrlPkg::fwdSelT fwdA, fwdB,
	input logic [rvIsaPkg::xlen-1:0] a, b, imm, pc, aluOutM, resultW,
	input logic aluSrcImm,
	input coreCtrlPkg::aluOpT aluOp,
	input coreCtrlPkg::resultSrcT resultSrc,
	output logic [rvIsaPkg::xlen-1:0] aluOut, storeData
);

	logic [rvIsaPkg::xlen-1:0] srcA, srcB, aluRes;
	logic [4:0] shamt;

	// memory stage is newer than writeback, so it wins
	always_comb begin
		case (fwdA)
			coreCtrlPkg::fwdMem: srcA = aluOutM;
			coreCtrlPkg::fwdWb: srcA = resultW;
			default: srcA = a;
		endcase
		case (fwdB)
			coreCtrlPkg::fwdMem: storeData = aluOutM;
			coreCtrlPkg::fwdWb: storeData = resultW;
			default: storeData = b;
		endcase
	end

	// forwarded rs2 doubles as the store data
	assign srcB = aluSrcImm ? imm : storeData;
	assign shamt = srcB[4:0];

	always_comb begin
		case (aluOp)
			coreCtrlPkg::sub: aluRes = srcA - srcB;
			coreCtrlPkg::sll: aluRes = srcA << shamt;
			coreCtrlPkg::slt: aluRes = {31'b0, $signed(srcA) < $signed(srcB)};
			coreCtrlPkg::sltu: aluRes = {31'b0, srcA < srcB};
			coreCtrlPkg::xorOp: aluRes = srcA ^ srcB;
			coreCtrlPkg::srl: aluRes = srcA >> shamt;
			coreCtrlPkg::sra: aluRes = $signed(srcA) >>> shamt;
			coreCtrlPkg::orOp: aluRes = srcA | srcB;
			coreCtrlPkg::andOp: aluRes = srcA & srcB;
			default: aluRes = srcA + srcB;
		endcase
	end

	// link value for jumps, lui and auipc bypass the alu
	always_comb begin
		case (resultSrc)
			coreCtrlPkg::pcPlus4: aluOut = pc + 32'd4;
			coreCtrlPkg::immU: aluOut = imm;
			coreCtrlPkg::pcImmU: aluOut = pc + imm;
			default: aluOut = aluRes;
		endcase
	end

endmodule

/* verilog/memAlign.sv */
//******************
// sub-word alignment between the EX/MEM register and data memory
// loads are extracted from the read word, stores merged back into it
//******************
`timescale 1ns/100ps

module memAlign (
	input rvIsaPkg::funct3T funct3,
	input logic [31:0] addr, storeData, rdWord,
	output logic [31:0] loadData, wrWord
);

	logic [7:0] byteLane;
	logic [15:0] halfLane;

	// lane chosen by the low address bits
	assign byteLane = rdWord[{addr[1:0], 3'b000} +: 8];
	assign halfLane = addr[1] ? rdWord[31:16] : rdWord[15:0];

	// sign or zero extend by size
	always_comb begin
		case (funct3)
			rvIsaPkg::memB: loadData = {{24{byteLane[7]}}, byteLane};
			rvIsaPkg::memH: loadData = {{16{halfLane[15]}}, halfLane};
			rvIsaPkg::memBu: loadData = {24'b0, byteLane};
			rvIsaPkg::memHu: loadData = {16'b0, halfLane};
			rvIsaPkg::memW: loadData = rdWord;
			default: loadData = rdWord;
		endcase
	end

	// memory takes whole words only
	// so a byte or half replaces its lane in the current word
	always_comb begin
		wrWord = rdWord;
		case (funct3)
			rvIsaPkg::memB: wrWord[{addr[1:0], 3'b000} +: 8] = storeData[7:0];
			rvIsaPkg::memH: wrWord[{addr[1], 4'b0000} +: 16] = storeData[15:0];
			rvIsaPkg::memW: wrWord = storeData;
			default: wrWord = storeData;
		endcase
	end

endmodule

/* verilog/hazardUnit.sv */
//******************
// bypass selects, stall and squash for the five-stage pipe
//******************
`timescale 1ns/100ps

module hazardUnit (
	input logic [rvIsaPkg::regAddrW-1:0] rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
	input logic regWriteE, regWriteM, regWriteW, memReadE, memReadM,
	input logic usesRs1D, usesRs2D, branchUseD, redirectD,
	output coreCtrlPkg::fwdSelT fwdAE, fwdBE,
	output logic fwdAD, fwdBD, stall, squash
);

	logic hitM1, hitM2, hitE1, hitE2, loadUse, branchWait;

	// execute bypass, memory stage first
	always_comb begin
		if (regWriteM && rdM != '0 && rdM == rs1E)
			fwdAE = coreCtrlPkg::fwdMem;
		else if (regWriteW && rdW != '0 && rdW == rs1E)
			fwdAE = coreCtrlPkg::fwdWb;
		else
			fwdAE = coreCtrlPkg::fwdNone;
		if (regWriteM && rdM != '0 && rdM == rs2E)
			fwdBE = coreCtrlPkg::fwdMem;
		else if (regWriteW && rdW != '0 && rdW == rs2E)
			fwdBE = coreCtrlPkg::fwdWb;
		else
			fwdBE = coreCtrlPkg::fwdNone;
	end

	// decode source pending in execute or memory
	assign hitE1 = regWriteE && rdE != '0 && usesRs1D && rdE == rs1D;
	assign hitE2 = regWriteE && rdE != '0 && usesRs2D && rdE == rs2D;
	assign hitM1 = regWriteM && rdM != '0 && usesRs1D && rdM == rs1D;
	assign hitM2 = regWriteM && rdM != '0 && usesRs2D && rdM == rs2D;

	// compare operands in decode take the memory stage alu result
	// writeback needs nothing, the register file already has it
	assign fwdAD = hitM1;
	assign fwdBD = hitM2;

	// load result reaches execute only from writeback
	assign loadUse = memReadE && (hitE1 || hitE2);
	// a compare cannot wait on execute, nor on a load still in memory
	assign branchWait = branchUseD && ((hitE1 || hitE2) || (memReadM && (hitM1 || hitM2)));

	assign stall = loadUse || branchWait;
	// redirect only counts once its operands are ready
	assign squash = redirectD && !stall;

endmodule

/* verilog/rvCore.sv */
//******************
// RV32I five-stage core, fetch decode execute memory writeback
// holds the pipeline registers, branch resolution and the writeback mux
//******************
`timescale 1ns/100ps

module rvCore (
	input logic clk,
	input logic reset,
	output logic [31:0] imemAddr,
	input logic [31:0] imemData,
	output logic [31:0] dmemAddr, dmemWrData,
	output logic dmemWe,
	input logic [31:0] dmemRdData
);

	logic [31:0] pcF;
	// decode
	logic [31:0] instrD, pcD, immD, rd1D, rd2D, cmpAD, cmpBD, targetD, jalrTargetD;
	logic [4:0] rs1D, rs2D, rdD;
	coreCtrlPkg::aluOpT aluOpD;
	coreCtrlPkg::resultSrcT resultSrcD;
	coreCtrlPkg::pcSelT pcSelD;
	rvIsaPkg::funct3T funct3D;
	logic aluSrcImmD, regWriteD, memReadD, memWriteD, isBranchD, isJalD, isJalrD;
	logic takenD, redirectD, usesRs1D, usesRs2D, branchUseD;
	// execute
	logic [31:0] rd1E, rd2E, immE, pcE, aluOutE, storeDataE;
	logic [4:0] rs1E, rs2E, rdE;
	coreCtrlPkg::aluOpT aluOpE;
	coreCtrlPkg::resultSrcT resultSrcE;
	rvIsaPkg::funct3T funct3E;
	logic aluSrcImmE, regWriteE, memReadE, memWriteE;
	// memory and writeback
	logic [31:0] aluOutM, storeDataM, loadDataM, aluOutW, loadDataW, resultW;
	logic [4:0] rdM, rdW;
	rvIsaPkg::funct3T funct3M;
	logic regWriteM, memReadM, memWriteM, regWriteW, memReadW;
	// hazard
	coreCtrlPkg::fwdSelT fwdAE, fwdBE;
	logic fwdAD, fwdBD, stall, squash;

	pcGen pcGen0 (.clk(clk), .reset(reset), .stall(stall), .pcSel(pcSelD),
		.branchTarget(targetD), .jalTarget(targetD), .jalrTarget(jalrTargetD), .pc(pcF));
	assign imemAddr = pcF;

	// IF/ID, a zero word decodes as a bubble
	always_ff @(posedge clk) begin
		if (!reset || squash) begin
			instrD <= '0;
		end else if (!stall) begin
			instrD <= imemData;
		end
	end
	always_ff @(posedge clk) begin
		if (!stall) begin
			pcD <= pcF;
		end
	end

	instDecode dec0 (.instr(instrD), .rs1(rs1D), .rs2(rs2D), .rd(rdD), .aluOp(aluOpD),
		.aluSrcImm(aluSrcImmD), .regWrite(regWriteD), .memRead(memReadD),
		.memWrite(memWriteD), .isBranch(isBranchD), .isJal(isJalD), .isJalr(isJalrD),
		.resultSrc(resultSrcD), .funct3(funct3D), .imm(immD));

	regFile rf0 (.clk(clk), .reset(reset), .we(regWriteW), .ra1(rs1D), .ra2(rs2D),
		.wa(rdW), .wd(resultW), .rd1(rd1D), .rd2(rd2D));

	// which sources really matter, from the decoded control
	assign usesRs1D = isBranchD || isJalrD || memWriteD ||
		(regWriteD && resultSrcD == coreCtrlPkg::alu);
	assign usesRs2D = isBranchD || memWriteD ||
		(regWriteD && resultSrcD == coreCtrlPkg::alu && !aluSrcImmD);
	assign branchUseD = isBranchD || isJalrD;

	// compare and jalr base see the memory stage result
	assign cmpAD = fwdAD ? aluOutM : rd1D;
	assign cmpBD = fwdBD ? aluOutM : rd2D;

	always_comb begin
		case (funct3D)
			rvIsaPkg::brEq: takenD = cmpAD == cmpBD;
			rvIsaPkg::brNe: takenD = cmpAD != cmpBD;
			rvIsaPkg::brLt: takenD = $signed(cmpAD) < $signed(cmpBD);
			rvIsaPkg::brGe: takenD = $signed(cmpAD) >= $signed(cmpBD);
			rvIsaPkg::brLtu: takenD = cmpAD < cmpBD;
			rvIsaPkg::brGeu: takenD = cmpAD >= cmpBD;
			default: takenD = 1'b0;
		endcase
	end

	// one adder serves branch and jal, immD already has the right format
	assign targetD = pcD + immD;
	assign jalrTargetD = (cmpAD + immD) & ~32'd1;

	always_comb begin
		if (isJalD)
			pcSelD = coreCtrlPkg::jalTarget;
		else if (isJalrD)
			pcSelD = coreCtrlPkg::jalrTarget;
		else if (isBranchD && takenD)
			pcSelD = coreCtrlPkg::branchTarget;
		else
			pcSelD = coreCtrlPkg::seq;
	end
	assign redirectD = pcSelD != coreCtrlPkg::seq;

	hazardUnit haz0 (.rs1D(rs1D), .rs2D(rs2D), .rs1E(rs1E), .rs2E(rs2E), .rdE(rdE),
		.rdM(rdM), .rdW(rdW), .regWriteE(regWriteE), .regWriteM(regWriteM),
		.regWriteW(regWriteW), .memReadE(memReadE), .memReadM(memReadM),
		.usesRs1D(usesRs1D), .usesRs2D(usesRs2D), .branchUseD(branchUseD),
		.redirectD(redirectD), .fwdAE(fwdAE), .fwdBE(fwdBE), .fwdAD(fwdAD), .fwdBD(fwdBD),
		.stall(stall), .squash(squash));

	// ID/EX, a stall leaves a bubble behind
	always_ff @(posedge clk) begin
		if (!reset || stall) begin
			regWriteE <= 1'b0;
			memReadE <= 1'b0;
			memWriteE <= 1'b0;
		end else begin
			regWriteE <= regWriteD;
			memReadE <= memReadD;
			memWriteE <= memWriteD;
		end
	end
	always_ff @(posedge clk) begin
		rd1E <= rd1D;
		rd2E <= rd2D;
		immE <= immD;
		pcE <= pcD;
		rs1E <= rs1D;
		rs2E <= rs2D;
		rdE <= rdD;
		aluOpE <= aluOpD;
		aluSrcImmE <= aluSrcImmD;
		resultSrcE <= resultSrcD;
		funct3E <= funct3D;
	end

	aluExec ex0 (.fwdA(fwdAE), .fwdB(fwdBE), .a(rd1E), .b(rd2E), .imm(immE), .pc(pcE),
		.aluOutM(aluOutM), .resultW(resultW), .aluSrcImm(aluSrcImmE), .aluOp(aluOpE),
		.resultSrc(resultSrcE), .aluOut(aluOutE), .storeData(storeDataE));

	// EX/MEM
	always_ff @(posedge clk) begin
		if (!reset) begin
			regWriteM <= 1'b0;
			memReadM <= 1'b0;
			memWriteM <= 1'b0;
		end else begin
			regWriteM <= regWriteE;
			memReadM <= memReadE;
			memWriteM <= memWriteE;
		end
	end
	always_ff @(posedge clk) begin
		aluOutM <= aluOutE;
		storeDataM <= storeDataE;
		rdM <= rdE;
		funct3M <= funct3E;
	end

	memAlign mem0 (.funct3(funct3M), .addr(aluOutM), .storeData(storeDataM),
		.rdWord(dmemRdData), .loadData(loadDataM), .wrWord(dmemWrData));
	assign dmemAddr = aluOutM;
	assign dmemWe = memWriteM;

	// MEM/WB
	always_ff @(posedge clk) begin
		if (!reset) begin
			regWriteW <= 1'b0;
			memReadW <= 1'b0;
		end else begin
			regWriteW <= regWriteM;
			memReadW <= memReadM;
		end
	end
	always_ff @(posedge clk) begin
		aluOutW <= aluOutM;
		loadDataW <= loadDataM;
		rdW <= rdM;
	end

	// loads write back memory data, all else the execute result
	assign resultW = memReadW ? loadDataW : aluOutW;

endmodule

/* verif/clockGen.sv */
//********************
// testbench clock and active-low reset
// 10 ns period, reset released on a falling edge
//********************
`timescale 1ns/100ps

module clockGen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		reset = 1'b0;
		// four rising edges in reset, release away from the sampling edge
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset <= 1'b1;
	end

	always #5 clk = ~clk;

endmodule

/* verif/rvCoreTb.sv */
//********************
// testbench for rvCore, memories answer combinationally
// program, data and expected stores come from verif/rvCoreTests.txt
//********************
`timescale 1ns/100ps

module rvCoreTb;

	localparam logic [31:0] nopWord = 32'h0000_0013;
	localparam int waitLimit = 2000;

	logic clk, reset;
	logic [31:0] imemAddr, imemData, dmemAddr, dmemWrData, dmemRdData;
	logic dmemWe;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic [31:0] holdAddr [$];
	logic [31:0] lfsr;

	clockGen clkGen0 (.clk(clk), .reset(reset));

	rvCore UUT (.clk(clk), .reset(reset), .imemAddr(imemAddr), .imemData(imemData),
		.dmemAddr(dmemAddr), .dmemWrData(dmemWrData), .dmemWe(dmemWe),
		.dmemRdData(dmemRdData));

	// both memories word addressed, 1 KB each
	assign imemData = imem[imemAddr[9:2]];
	assign dmemRdData = dmem[dmemAddr[9:2]];

	// store already carries the merged word
	always @(posedge clk) begin
		if (dmemWe)
			dmem[dmemAddr[9:2]] <= dmemWrData;
	end

	// galois lfsr, one step per bit taken
	function automatic int takeBits(input int n);
		int val;
		logic lsb;
		val = 0;
		for (int i = 0; i < n; i++) begin
			lsb = lfsr[0];
			lfsr = lfsr >> 1;
			if (lsb)
				lfsr = lfsr ^ 32'h8020_0003;
			val = (val << 1) | int'(lsb);
		end
		return val;
	endfunction

	task automatic checkStore(input string sig, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, sig, got, exp);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	task automatic checkFetchAddr(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: imemAddr got %h expected %h", $time, got, exp);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	// next falling edge with a store pending for the coming rising edge
	task automatic waitStore();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!dmemWe && cycles < waitLimit) begin
			@(negedge clk);
			cycles++;
		end
		if (!dmemWe) begin
			$display("no store arrived before timeout");
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	// each hold word is a jal to itself, replaced by a nop after a random idle
	task automatic releaseHolds();
		int cycles;
		int idle;
		foreach (holdAddr[h]) begin
			cycles = 0;
			while (!(reset && imemAddr == holdAddr[h]) && cycles < waitLimit) begin
				@(negedge clk);
				cycles++;
			end
			if (!(reset && imemAddr == holdAddr[h])) begin
				$display("program never reached the self loop at %h", holdAddr[h]);
				$display("** FAIL **");
				$fatal(1);
			end
			idle = takeBits(4);
			repeat (idle) @(negedge clk);
			imem[holdAddr[h][9:2]] = nopWord;
		end
	endtask

	task automatic loadTests();
		int fd;
		int code;
		int pc;
		int ch;
		byte kind;
		string line;
		logic [31:0] a, w;
		pc = 0;
		fd = $fopen("verif/rvCoreTests.txt", "r");
		if (fd == 0) begin
			$display("cannot open verif/rvCoreTests.txt");
			$display("** FAIL **");
			$fatal(1);
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, " %c", kind);
			if (code == 1) begin
				case (kind)
					"P": begin
						// program words run to the end of the line
						ch = $fgetc(fd);
						while (ch == " ") begin
							code = $fscanf(fd, "%h", w);
							imem[pc] = w;
							pc++;
							ch = $fgetc(fd);
						end
					end
					"D": begin
						code = $fscanf(fd, "%h %h", a, w);
						dmem[a[9:2]] = w;
					end
					"S": begin
						code = $fscanf(fd, "%h %h", a, w);
						expAddr.push_back(a);
						expData.push_back(w);
					end
					"H": begin
						code = $fscanf(fd, "%h", a);
						holdAddr.push_back(a);
					end
					default: code = $fgets(line, fd);
				endcase
			end
		end
		$fclose(fd);
	endtask

	initial begin
		lfsr = 32'hb2e0_bc9b;
		// fills track the address
		// a code word ending in 00 is no valid opcode, so stray fetches are bubbles
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'hc0de_0000 | (i << 2);
			dmem[i] = 32'hd0d0_0000 | (i << 2);
		end
		loadTests();
		fork
			releaseHolds();
		join_none
		// fetch sits at the reset vector while reset is held
		@(negedge clk);
		checkFetchAddr(imemAddr, 32'h0000_0000);
		foreach (expAddr[k]) begin
			waitStore();
			checkStore("dmemAddr", dmemAddr, expAddr[k]);
			checkStore("dmemWrData", dmemWrData, expData[k]);
		end
		$display("** PASS **");
		$finish;
	end

endmodule

/* verif/rvCoreTests.txt */
# P word: program from 0 | D addr word: data | S addr word: expected store in order
# H addr: self loop released after an idle period
H 0
P 0000006F 10000513 FFB00093 00300113 4020D1B3 00352023 0020A233 0020B2B3
P 01C0D313 401103B3 00452223 00552423 00652623 00752823 0F00C413 00441493
P 00952A23 0000006F
H 44
D 180 F2347F85
D 184 11223344
P 08052583 00158613 00C52C23 08050683 08154703 08251783 08055803 00D52E23
P 02E52023 02F52223 03052423 081502A3 08B51323 08D503A3 08C51223 08250223
P 08650323 0000006F
H 8C
# branches, each taken one skips a store, each not-taken one sets a bit in x20
P 00210463 02152823 00208463 001A6A13 00209463 02152823 00211463 002A6A13
P 0020C463 02152823 00114463 004A6A13 00115463 02152823 0020D463 008A6A13
P 00116463 02152823 0020E463 010A6A13 0020F463 02152823 00117463 020A6A13
P 03452623 00700A93 002A9463 02152823 00800B6F 02152823 00CB0BE7 02152823
P ABCDEC37 00012C97 03652A23 03752C23 03852E23 05952023 0000006F
S 100 FFFFFFFF
S 104 00000001
S 108 00000000
S 10C 0000000F
S 110 00000008
S 114 FFFFF0B0
S 118 F2347F86
S 11C FFFFFF85
S 120 0000007F
S 124 FFFFF234
S 128 00007F85
S 185 1122FB44
S 186 7F85FB44
S 187 8585FB44
S 184 85857F86
S 184 85857F03
S 186 850F7F03
S 12C 0000003F
S 134 00000104
S 138 0000010C
S 13C ABCDE000
S 140 00012114

/* flist.f */
verilog/rvIsaPkg.sv
verilog/coreCtrlPkg.sv
verilog/pcGen.sv
verilog/instDecode.sv
verilog/regFile.sv
verilog/aluExec.sv
verilog/memAlign.sv
verilog/hazardUnit.sv
verilog/rvCore.sv
verif/clockGen.sv
verif/rvCoreTb.sv

/* Bender.yml */
package:
  name: rvcore

sources:
  - verilog/rvIsaPkg.sv
  - verilog/coreCtrlPkg.sv
  - verilog/pcGen.sv
  - verilog/instDecode.sv
  - verilog/regFile.sv
  - verilog/aluExec.sv
  - verilog/memAlign.sv
  - verilog/hazardUnit.sv
  - verilog/rvCore.sv
  - target: simulation
    files:
      - verif/clockGen.sv
      - verif/rvCoreTb.sv
